//--- dv/sb_stimulus.txt
# name op a b c, operands in hex, unused ones are 0
# port: a offset, b data; cmd: a byte; reply, status: a expected byte
# play: a tc, b length minus one, c speaker; irq: a expected level; ack: none
rst port 6 1 0
rst port 6 0 0
rst reply AA 0 0
rst status 7F 0 0
ver cmd E1 0 0
ver reply 03 0 0
ver reply 00 0 0
chk cmd E0 0 0
chk cmd 5A 0 0
chk reply A5 0 0
chk0 cmd E0 0 0
chk0 cmd 00 0 0
chk0 reply FF 0 0
spk_on cmd D1 0 0
spk_on cmd D8 0 0
spk_on reply FF 0 0
spk_off cmd D3 0 0
spk_off cmd D8 0 0
spk_off reply 00 0 0
play_on play F0 3 1
play_on ack 0 0 0
play_off play F0 2 0
play_off ack 0 0 0
irq_f2 cmd F2 0 0
irq_f2 irq 1 0 0
irq_f2 ack 0 0 0

//--- project.f
+incdir+hw
hw/sb_pkg.sv
hw/sb_port_io.sv
hw/sb_dsp_cmd.sv
hw/sb_play_timer.sv
hw/sb_sample_out.sv
hw/sb_dsp_top.sv
dv/tb_sb_dsp.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
	--top-module tb_sb_dsp -f project.f -Mdir obj_dir

sim_out=$(./obj_dir/Vtb_sb_dsp)
echo "$sim_out"

if echo "$sim_out" | grep -q "all tests passed"; then
	exit 0
fi
exit 1

//--- dv/tb_sb_dsp.sv
`timescale 1ns/100ps
`include "sb_params.svh"

module tb_sb_dsp;

	import sb_pkg::*;

	localparam int POLL_LIMIT = 64;

	logic CLK;
	logic dsp_reset;
	logic i_io_wr;
	logic i_io_rd;
	port_ofs_t i_io_ofs;
	dsp_byte_t i_io_wdata;
	logic i_dma_valid;
	dsp_byte_t i_dma_data;
	dsp_byte_t o_io_rdata;
	logic o_dma_req;
	sample_t o_sample;
	logic o_sample_valid;
	logic o_irq;

	int checks;
	int errors;
	int timeouts;
	int req_count;
	int fd;
	int got;
	int fields;
	logic [8*96-1:0] line;
	logic [127:0] test_name;
	logic [63:0] op;
	logic [15:0] arg_a;
	logic [15:0] arg_b;
	logic [15:0] arg_c;

	sb_dsp_top dut
	(
		.CLK(CLK),
		.dsp_reset(dsp_reset),
		.i_io_wr(i_io_wr),
		.i_io_rd(i_io_rd),
		.i_io_ofs(i_io_ofs),
		.i_io_wdata(i_io_wdata),
		.i_dma_valid(i_dma_valid),
		.i_dma_data(i_dma_data),
		.o_io_rdata(o_io_rdata),
		.o_dma_req(o_dma_req),
		.o_sample(o_sample),
		.o_sample_valid(o_sample_valid),
		.o_irq(o_irq)
	);

	initial
	begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// dma requests seen since reset
	always @(posedge CLK)
	begin
		if (dsp_reset)
			req_count <= 0;
		else if (o_dma_req)
			req_count <= req_count + 1;
	end

	task automatic check_byte(input dsp_byte_t exp, input dsp_byte_t act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("[FAIL] %0s: expected %02h, got %02h", test_name, exp, act);
		end
	endtask

	task automatic check_number(input int exp, input int act);
		checks++;
		if (exp != act)
		begin
			errors++;
			$display("[FAIL] %0s: expected %0d, got %0d", test_name, exp, act);
		end
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("%0s: gave up waiting for %0s", test_name, what);
	endtask

	task automatic write_port(input port_ofs_t ofs, input dsp_byte_t data);
		@(posedge CLK);
		i_io_wr <= 1'b1;
		i_io_ofs <= ofs;
		i_io_wdata <= data;
		@(posedge CLK);
		i_io_wr <= 1'b0;
	endtask

	// rdata is valid one cycle after the strobe
	task automatic read_port(input port_ofs_t ofs, output dsp_byte_t data);
		@(posedge CLK);
		i_io_rd <= 1'b1;
		i_io_ofs <= ofs;
		@(posedge CLK);
		i_io_rd <= 1'b0;
		@(posedge CLK);
		data = o_io_rdata;
	endtask

	task automatic write_command(input dsp_byte_t code);
		dsp_byte_t data;
		int tries;
		data = 8'hFF;
		tries = 0;
		while (data[7] && tries < POLL_LIMIT)
		begin
			read_port(`SB_PORT_WRITE, data);
			tries++;
		end
		if (data[7])
			report_timeout("the write port to drop busy");
		else
			write_port(`SB_PORT_WRITE, code);
	endtask

	task automatic read_reply(input dsp_byte_t exp);
		dsp_byte_t data;
		int tries;
		data = 8'h7F;
		tries = 0;
		while (!data[7] && tries < POLL_LIMIT)
		begin
			read_port(`SB_PORT_STATUS, data);
			tries++;
		end
		if (!data[7])
			report_timeout("a pending reply");
		else
		begin
			read_port(`SB_PORT_READ, data);
			check_byte(exp, data);
		end
	endtask

	task automatic wait_irq(input logic exp, input int limit);
		int cycles;
		cycles = 0;
		@(posedge CLK);
		while (o_irq !== exp && cycles < limit)
		begin
			@(posedge CLK);
			cycles++;
		end
		if (o_irq !== exp)
			report_timeout("the IRQ line to change");
	endtask

	task automatic play_block(input dsp_byte_t tc, input blk_len_t len, input logic spk);
		int base;
		int req;
		int cycles;
		int limit;
		int delay;
		int exp_sample;
		logic [31:0] word;
		dsp_byte_t b;
		// one period is (256 - tc) ticks of about 67 clocks
		limit = (256 - int'(tc)) * 80 + 100;
		write_command(spk ? `SB_CMD_SPK_ON : `SB_CMD_SPK_OFF);
		write_command(`SB_CMD_TC);
		write_command(tc);
		base = req_count;
		write_command(`SB_CMD_DMA8);
		write_command(len[7:0]);
		write_command(len[15:8]);
		req = 0;
		while (timeouts == 0 && req <= int'(len))
		begin
			cycles = 0;
			@(posedge CLK);
			while (!o_dma_req && cycles < limit)
			begin
				@(posedge CLK);
				cycles++;
			end
			if (!o_dma_req)
				report_timeout("a DMA request");
			else
			begin
				// irq stays low until the block is done
				check_number(0, int'(o_irq));
				word = $urandom;
				delay = 1 + int'(word % 8);
				word = $urandom;
				b = word[7:0];
				exp_sample = spk ? (int'(b) - 128) * 128 : 0;
				repeat (delay) @(posedge CLK);
				i_dma_valid <= 1'b1;
				i_dma_data <= b;
				@(posedge CLK);
				i_dma_valid <= 1'b0;
				cycles = 0;
				@(posedge CLK);
				while (!o_sample_valid && cycles < 8)
				begin
					@(posedge CLK);
					cycles++;
				end
				if (!o_sample_valid)
					report_timeout("an output sample");
				else
					check_number(exp_sample, int'(o_sample));
				req++;
			end
		end
		if (timeouts == 0)
		begin
			wait_irq(1'b1, 16);
			// no request may follow the last one in this window
			repeat (2 * limit) @(posedge CLK);
			check_number(int'(len) + 1, req_count - base);
		end
	endtask

	task automatic run_step;
		dsp_byte_t data;
		if (op == 64'("port"))
			write_port(arg_a[3:0], arg_b[7:0]);
		else if (op == 64'("cmd"))
			write_command(arg_a[7:0]);
		else if (op == 64'("reply"))
			read_reply(arg_a[7:0]);
		else if (op == 64'("status"))
		begin
			read_port(`SB_PORT_STATUS, data);
			check_byte(arg_a[7:0], data);
		end
		else if (op == 64'("play"))
			play_block(arg_a[7:0], arg_b, arg_c[0]);
		else if (op == 64'("irq"))
			wait_irq(arg_a[0], 32);
		else if (op == 64'("ack"))
		begin
			read_port(`SB_PORT_STATUS, data);
			wait_irq(1'b0, 4);
		end
		else
		begin
			errors++;
			$display("%0s: unknown operation %0s in the stimulus file", test_name, op);
		end
	endtask

	initial
	begin
		checks = 0;
		errors = 0;
		timeouts = 0;
		test_name = 128'("reset");
		void'($urandom(32'h436d_e0e4));
		dsp_reset = 1'b1;
		i_io_wr = 1'b0;
		i_io_rd = 1'b0;
		i_io_ofs = '0;
		i_io_wdata = '0;
		i_dma_valid = 1'b0;
		i_dma_data = '0;
		repeat (16) @(posedge CLK);
		dsp_reset <= 1'b0;
		@(posedge CLK);
		fd = $fopen("dv/sb_stimulus.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("could not open the stimulus file dv/sb_stimulus.txt");
		end
		else
		begin
			while (!$feof(fd) && timeouts == 0)
			begin
				line = '0;
				got = $fgets(line, fd);
				fields = $sscanf(line, "%s %s %h %h %h", test_name, op, arg_a, arg_b, arg_c);
				// lines led by a lone # are comments
				if (got > 0 && fields == 5 && test_name != 128'("#"))
					run_step();
			end
			$fclose(fd);
		end
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0 && checks > 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- hw/sb_dsp_top.sv
`timescale 1ns/100ps
`include "sb_params.svh"

module sb_dsp_top
	(
	input logic CLK,
	input logic dsp_reset,
	input logic i_io_wr,
	input logic i_io_rd,
	input sb_pkg::port_ofs_t i_io_ofs,
	input sb_pkg::dsp_byte_t i_io_wdata,
	input logic i_dma_valid,
	input sb_pkg::dsp_byte_t i_dma_data,
	output sb_pkg::dsp_byte_t o_io_rdata,
	output logic o_dma_req,
	output sb_pkg::sample_t o_sample,
	output logic o_sample_valid,
	output logic o_irq
	);

	import sb_pkg::*;

	logic cmd_valid;
	dsp_byte_t cmd_byte;
	logic cmd_take;
	logic reply_load;
	dsp_byte_t reply_byte;
	logic reply_pending;
	logic busy;
	logic soft_reset;
	logic status_ack;
	logic play_start;
	blk_len_t play_len;
	dsp_byte_t tc;
	logic pause;
	logic speaker;
	logic block_done;

	sb_port_io u_port_io
	(
		.CLK(CLK),
		.dsp_reset(dsp_reset),
		.i_io_wr(i_io_wr),
		.i_io_rd(i_io_rd),
		.i_io_ofs(i_io_ofs),
		.i_io_wdata(i_io_wdata),
		.i_cmd_take(cmd_take),
		.i_reply_load(reply_load),
		.i_reply_byte(reply_byte),
		.i_busy(busy),
		.o_io_rdata(o_io_rdata),
		.o_cmd_valid(cmd_valid),
		.o_cmd_byte(cmd_byte),
		.o_reply_pending(reply_pending),
		.o_soft_reset(soft_reset),
		.o_status_ack(status_ack)
	);

	sb_dsp_cmd u_dsp_cmd
	(
		.CLK(CLK),
		.dsp_reset(dsp_reset),
		.i_soft_reset(soft_reset),
		.i_cmd_valid(cmd_valid),
		.i_cmd_byte(cmd_byte),
		.i_reply_pending(reply_pending),
		.i_status_ack(status_ack),
		.i_block_done(block_done),
		.o_cmd_take(cmd_take),
		.o_reply_load(reply_load),
		.o_reply_byte(reply_byte),
		.o_busy(busy),
		.o_play_start(play_start),
		.o_play_len(play_len),
		.o_tc(tc),
		.o_pause(pause),
		.o_speaker(speaker),
		.o_irq(o_irq)
	);

	sb_play_timer u_play_timer
	(
		.CLK(CLK),
		.dsp_reset(dsp_reset),
		.i_soft_reset(soft_reset),
		.i_play_start(play_start),
		.i_play_len(play_len),
		.i_tc(tc),
		.i_pause(pause),
		.o_dma_req(o_dma_req),
		.o_block_done(block_done)
	);

	sb_sample_out u_sample_out
	(
		.CLK(CLK),
		.dsp_reset(dsp_reset),
		.i_dma_valid(i_dma_valid),
		.i_dma_data(i_dma_data),
		.i_speaker(speaker),
		.o_sample(o_sample),
		.o_sample_valid(o_sample_valid)
	);

endmodule

//--- hw/sb_sample_out.sv
`timescale 1ns/100ps
`include "sb_params.svh"

module sb_sample_out
	(
	input logic CLK,
	input logic dsp_reset,
	input logic i_dma_valid,
	input sb_pkg::dsp_byte_t i_dma_data,
	input logic i_speaker,
	output sb_pkg::sample_t o_sample,
	output logic o_sample_valid
	);

	import sb_pkg::*;

	dsp_byte_t signed_byte;
	sample_t scaled;

	// unsigned pcm to two's complement
	assign signed_byte = {~i_dma_data[7], i_dma_data[6:0]};

	// sign extend, times 128
	assign scaled = {signed_byte[7], signed_byte, 7'h00};

	always_ff @(posedge CLK)
	begin
		if (dsp_reset)
			o_sample_valid <= 1'b0;
		else
			o_sample_valid <= i_dma_valid;
	end

	always_ff @(posedge CLK)
	begin
		if (i_dma_valid)
		begin
			if (i_speaker)
				o_sample <= scaled;
			else
				o_sample <= '0;
		end
	end

endmodule

//--- hw/sb_play_timer.sv
`timescale 1ns/100ps
`include "sb_params.svh"

module sb_play_timer
	(
	input logic CLK,
	input logic dsp_reset,
	input logic i_soft_reset,
	input logic i_play_start,
	input sb_pkg::blk_len_t i_play_len,
	input sb_pkg::dsp_byte_t i_tc,
	input logic i_pause,
	output logic o_dma_req,
	output logic o_block_done
	);

	import sb_pkg::*;

	tick_acc_t tick_acc;
	logic [`SB_TICK_WIDTH:0] tick_sum;
	logic tick;
	dsp_byte_t rate_cnt;
	logic wrap;
	logic playing;
	blk_len_t len_cnt;
	logic issue;
	logic last_req;

	// carry out of the accumulator is one tick
	assign tick_sum = {1'b0, tick_acc} + {1'b0, tick_acc_t'(`SB_TICK_INC)};
	assign tick = tick_sum[`SB_TICK_WIDTH];

	assign wrap = tick && rate_cnt == 8'hFF;
	assign issue = wrap && playing && !i_pause;

	always_ff @(posedge CLK)
	begin
		if (dsp_reset)
			tick_acc <= '0;
		else
			tick_acc <= tick_sum[`SB_TICK_WIDTH-1:0];
	end

	// counts up from tc, so one period is 256 - tc ticks
	always_ff @(posedge CLK)
	begin
		if (dsp_reset)
			rate_cnt <= '0;
		else if (i_play_start || wrap)
			rate_cnt <= i_tc;
		else if (tick)
			rate_cnt <= rate_cnt + 8'd1;
	end

	always_ff @(posedge CLK)
	begin
		if (dsp_reset || i_soft_reset)
		begin
			playing <= 1'b0;
			len_cnt <= '0;
			o_dma_req <= 1'b0;
			last_req <= 1'b0;
			o_block_done <= 1'b0;
		end
		else
		begin
			o_dma_req <= issue;
			last_req <= issue && len_cnt == '0;
			o_block_done <= last_req;
			if (i_play_start)
			begin
				playing <= 1'b1;
				len_cnt <= i_play_len;
			end
			else if (issue)
			begin
				if (len_cnt == '0)
					playing <= 1'b0;
				else
					len_cnt <= len_cnt - 16'd1;
			end
		end
	end

endmodule

//--- hw/sb_dsp_cmd.sv
`timescale 1ns/100ps
`include "sb_params.svh"

module sb_dsp_cmd
	(
	input logic CLK,
	input logic dsp_reset,
	input logic i_soft_reset,
	input logic i_cmd_valid,
	input sb_pkg::dsp_byte_t i_cmd_byte,
	input logic i_reply_pending,
	input logic i_status_ack,
	input logic i_block_done,
	output logic o_cmd_take,
	output logic o_reply_load,
	output sb_pkg::dsp_byte_t o_reply_byte,
	output logic o_busy,
	output logic o_play_start,
	output sb_pkg::blk_len_t o_play_len,
	output sb_pkg::dsp_byte_t o_tc,
	output logic o_pause,
	output logic o_speaker,
	output logic o_irq
	);

	import sb_pkg::*;

	dsp_state_t state;
	dsp_state_t ret_state;
	dsp_byte_t len_lo;
	logic irq_cmd;

	assign irq_cmd = state == IDLE && i_cmd_valid && i_cmd_byte == `SB_CMD_IRQ;

	assign o_busy = i_cmd_valid || !(state == IDLE || state == WAIT_WRITE);

	// argument states consume the byte that woke WAIT_WRITE
	always_comb
	begin
		o_cmd_take = 1'b0;
		o_reply_load = 1'b0;
		o_reply_byte = `SB_REPLY_READY;
		case (state)
			IDLE:
				o_cmd_take = i_cmd_valid;
			READY_REPLY:
				o_reply_load = ~i_soft_reset;
			TC_ARG, LEN_LO, LEN_HI:
				o_cmd_take = 1'b1;
			CHECK_ARG:
			begin
				o_cmd_take = 1'b1;
				o_reply_load = 1'b1;
				o_reply_byte = ~i_cmd_byte;
			end
			VERSION_HI:
			begin
				o_reply_load = 1'b1;
				o_reply_byte = `SB_VERSION_MAJOR;
			end
			VERSION_LO:
			begin
				o_reply_load = 1'b1;
				o_reply_byte = `SB_VERSION_MINOR;
			end
			SPK_REPLY:
			begin
				o_reply_load = 1'b1;
				o_reply_byte = {8{o_speaker}};
			end
			default:
				o_cmd_take = 1'b0;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		o_play_start <= 1'b0;
		if (dsp_reset)
		begin
			state <= IDLE;
			ret_state <= IDLE;
			o_tc <= '0;
			o_pause <= 1'b0;
			o_speaker <= 1'b0;
		end
		else if (i_soft_reset)
		begin
			// speaker keeps its setting
			state <= READY_REPLY;
			ret_state <= IDLE;
			o_tc <= '0;
			o_pause <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (i_cmd_valid)
					begin
						case (i_cmd_byte)
							`SB_CMD_TC:
							begin
								state <= WAIT_WRITE;
								ret_state <= TC_ARG;
							end
							`SB_CMD_DMA8, `SB_CMD_DMA8_HS:
							begin
								state <= WAIT_WRITE;
								ret_state <= LEN_LO;
							end
							`SB_CMD_CHECK:
							begin
								state <= WAIT_WRITE;
								ret_state <= CHECK_ARG;
							end
							`SB_CMD_PAUSE:
								o_pause <= 1'b1;
							`SB_CMD_RESUME:
								o_pause <= 1'b0;
							`SB_CMD_SPK_ON:
								o_speaker <= 1'b1;
							`SB_CMD_SPK_OFF:
								o_speaker <= 1'b0;
							`SB_CMD_SPK_STATUS:
								state <= SPK_REPLY;
							`SB_CMD_VERSION:
								state <= VERSION_HI;
							// F2 and unknown codes stay idle
							default:
								state <= IDLE;
						endcase
					end
				end
				WAIT_READ:
				begin
					if (!i_reply_pending)
						state <= ret_state;
				end
				WAIT_WRITE:
				begin
					if (i_cmd_valid)
						state <= ret_state;
				end
				TC_ARG:
				begin
					o_tc <= i_cmd_byte;
					state <= IDLE;
				end
				LEN_LO:
				begin
					state <= WAIT_WRITE;
					ret_state <= LEN_HI;
				end
				LEN_HI:
				begin
					o_play_start <= 1'b1;
					o_pause <= 1'b0;
					state <= IDLE;
				end
				VERSION_HI:
				begin
					state <= WAIT_READ;
					ret_state <= VERSION_LO;
				end
				READY_REPLY, VERSION_LO, CHECK_ARG, SPK_REPLY:
				begin
					state <= WAIT_READ;
					ret_state <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK)
	begin
		if (state == LEN_LO)
			len_lo <= i_cmd_byte;
		if (state == LEN_HI)
			o_play_len <= {i_cmd_byte, len_lo};
	end

	// a new event beats the ack
	always_ff @(posedge CLK)
	begin
		if (dsp_reset || i_soft_reset)
			o_irq <= 1'b0;
		else if (irq_cmd || i_block_done)
			o_irq <= 1'b1;
		else if (i_status_ack)
			o_irq <= 1'b0;
	end

endmodule

//--- hw/sb_port_io.sv
`timescale 1ns/100ps
`include "sb_params.svh"

module sb_port_io
	(
	input logic CLK,
	input logic dsp_reset,
	input logic i_io_wr,
	input logic i_io_rd,
	input sb_pkg::port_ofs_t i_io_ofs,
	input sb_pkg::dsp_byte_t i_io_wdata,
	input logic i_cmd_take,
	input logic i_reply_load,
	input sb_pkg::dsp_byte_t i_reply_byte,
	input logic i_busy,
	output sb_pkg::dsp_byte_t o_io_rdata,
	output logic o_cmd_valid,
	output sb_pkg::dsp_byte_t o_cmd_byte,
	output logic o_reply_pending,
	output logic o_soft_reset,
	output logic o_status_ack
	);

	import sb_pkg::*;

	logic sel_reset;
	logic sel_read;
	logic sel_write;
	logic sel_status;
	dsp_byte_t reply_byte;

	assign sel_reset = i_io_ofs == `SB_PORT_RESET;
	assign sel_read = i_io_ofs == `SB_PORT_READ;
	assign sel_write = i_io_ofs == `SB_PORT_WRITE;
	assign sel_status = i_io_ofs == `SB_PORT_STATUS;

	// status read also acks the irq
	assign o_status_ack = i_io_rd && sel_status;

	always_ff @(posedge CLK)
	begin
		if (dsp_reset)
			o_soft_reset <= 1'b0;
		else if (i_io_wr && sel_reset)
			o_soft_reset <= i_io_wdata[0];
	end

	// command latch, a new write wins over a take
	always_ff @(posedge CLK)
	begin
		if (dsp_reset || o_soft_reset)
			o_cmd_valid <= 1'b0;
		else if (i_io_wr && sel_write)
			o_cmd_valid <= 1'b1;
		else if (i_cmd_take)
			o_cmd_valid <= 1'b0;
	end

	always_ff @(posedge CLK)
	begin
		if (i_io_wr && sel_write)
			o_cmd_byte <= i_io_wdata;
	end

	// reply latch
	always_ff @(posedge CLK)
	begin
		if (dsp_reset || o_soft_reset)
			o_reply_pending <= 1'b0;
		else if (i_reply_load)
			o_reply_pending <= 1'b1;
		else if (i_io_rd && sel_read)
			o_reply_pending <= 1'b0;
	end

	always_ff @(posedge CLK)
	begin
		if (i_reply_load)
			reply_byte <= i_reply_byte;
	end

	// read data holds until the next read
	always_ff @(posedge CLK)
	begin
		if (i_io_rd)
		begin
			case (i_io_ofs)
				`SB_PORT_STATUS:
					o_io_rdata <= {o_reply_pending, 7'h7F};
				`SB_PORT_WRITE:
					o_io_rdata <= {i_busy, 7'h7F};
				`SB_PORT_READ:
					o_io_rdata <= reply_byte;
				default:
					o_io_rdata <= 8'hFF;
			endcase
		end
	end

endmodule

//--- hw/sb_pkg.sv
`include "sb_params.svh"

package sb_pkg;

	typedef logic [3:0] port_ofs_t;
	typedef logic [7:0] dsp_byte_t;
	// transfer length minus one
	typedef logic [15:0] blk_len_t;
	typedef logic signed [15:0] sample_t;
	typedef logic [`SB_TICK_WIDTH-1:0] tick_acc_t;

	typedef enum logic [3:0]
	{
		IDLE,
		READY_REPLY,
		WAIT_READ,
		WAIT_WRITE,
		TC_ARG,
		LEN_LO,
		LEN_HI,
		VERSION_HI,
		VERSION_LO,
		CHECK_ARG,
		SPK_REPLY
	} dsp_state_t;

endpackage

//--- hw/sb_params.svh
`ifndef SB_PARAMS_SVH
`define SB_PARAMS_SVH

`define SB_PORT_RESET 4'h6
`define SB_PORT_READ 4'hA
`define SB_PORT_WRITE 4'hC
`define SB_PORT_STATUS 4'hE

`define SB_CMD_TC 8'h40
`define SB_CMD_DMA8 8'h14
`define SB_CMD_DMA8_HS 8'h91
`define SB_CMD_PAUSE 8'hD0
`define SB_CMD_SPK_ON 8'hD1
`define SB_CMD_SPK_OFF 8'hD3
`define SB_CMD_RESUME 8'hD4
`define SB_CMD_SPK_STATUS 8'hD8
`define SB_CMD_CHECK 8'hE0
`define SB_CMD_VERSION 8'hE1
`define SB_CMD_IRQ 8'hF2

`define SB_REPLY_READY 8'hAA
`define SB_VERSION_MAJOR 8'h03
`define SB_VERSION_MINOR 8'h00

`define SB_TICK_INC 1966
`define SB_TICK_WIDTH 17

`endif
